// ==== dv/pipe_cases.txt ====
# kind I presents the word, F flushes, B is a bubble
# columns: kind, instruction word (hex), expected commit data (hex)
I 00500093 0000000000000005
I 00708113 000000000000000c
I 002081b3 0000000000000011
I 40118233 000000000000000c
I 403002b3 ffffffffffffffef
I 0042c333 ffffffffffffffe3
I 002363b3 ffffffffffffffef
I 0033f433 0000000000000001
I 02841493 0000010000000000
I 80000537 ffffffff80000000
B 00000000 0000000000000000
I 009505b3 000000ff80000000
I 00500013 0000000000000005
I 00200633 000000000000000c
I 00100073 0000000000000000
I 0000a083 0000000000000000
I 00108693 0000000000000006
I 10000093 0000000000000100
I 7ff00113 0000000000000000
I 00100193 0000000000000000
F 00000000 0000000000000000
I 00208733 000000000000010c
I 00018793 0000000000000011
I 00479813 0000000000000110
I 40e808b3 0000000000000004

// ==== sources.f ====
verilog/pipe_pkg.sv
verilog/id_reg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/ex_reg.sv
verilog/alu_stage.sv
verilog/wb_reg.sv
verilog/pipe_top.sv
dv/pipe_props.sv
dv/pipe_checker.sv
dv/pipe_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f sources.f --top-module pipe_tb -o pipe_sim \
    && ./obj_dir/pipe_sim | tee /dev/stderr | grep -qx "sim passed" \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }

// ==== dv/pipe_tb.sv ====
// pipeline testbench
`default_nettype none
`timescale 1ns/1ps

module pipe_tb;

    localparam int XLEN      = pipe_pkg::xlen;
    localparam int MAX_CASES = 64;

    logic                       clk;
    logic                       rst_i;
    logic                       enable_i;
    logic                       flush_i;
    logic                       valid_i;
    logic [pipe_pkg::xlen-1:0]  pc_i;
    logic [pipe_pkg::ilen-1:0]  instr_i;
    logic [XLEN-1:0]            exp_val;
    wire                        commit_valid;
    wire  [pipe_pkg::xlen-1:0]  commit_pc;
    wire  [pipe_pkg::ilen-1:0]  commit_instr;
    wire                        commit_wen;
    wire  [4:0]                 commit_rd;
    wire  [XLEN-1:0]            commit_data;
    wire                        ebreak;
    int                         mismatch_cnt;
    int                         stray_cnt;
    int                         checked_cnt;
    int                         pending;

    logic [7:0]  case_kind [MAX_CASES];
    logic [31:0] case_word [MAX_CASES];
    logic [63:0] case_exp [MAX_CASES];
    int          ncases;
    int          cycle_limit;
    int          cycles;
    logic        armed;
    logic        done;
    logic [15:0] lfsr;

    pipe_top #(.XLEN(XLEN)) dut_i (
        .clk(clk), .rst_i(rst_i), .enable_i(enable_i), .flush_i(flush_i),
        .valid_i(valid_i), .pc_i(pc_i), .instr_i(instr_i),
        .commit_valid_o(commit_valid), .commit_pc_o(commit_pc),
        .commit_instr_o(commit_instr), .commit_wen_o(commit_wen),
        .commit_rd_o(commit_rd), .commit_data_o(commit_data), .ebreak_o(ebreak)
    );

    pipe_checker #(.XLEN(XLEN)) checker_i (
        .clk(clk), .rst_i(rst_i), .enable_i(enable_i), .flush_i(flush_i),
        .valid_i(valid_i), .pc_i(pc_i), .instr_i(instr_i), .exp_i(exp_val),
        .commit_valid_i(commit_valid), .commit_pc_i(commit_pc),
        .commit_instr_i(commit_instr), .commit_wen_i(commit_wen),
        .commit_rd_i(commit_rd), .commit_data_i(commit_data), .ebreak_i(ebreak),
        .mismatch_cnt_o(mismatch_cnt), .stray_cnt_o(stray_cnt),
        .checked_cnt_o(checked_cnt), .pending_o(pending)
    );

    bind pipe_top pipe_props #(.XLEN(XLEN)) props_i (
        .clk(clk), .rst_i(rst_i), .flush_i(flush_i), .enable_i(enable_i),
        .commit_valid_i(commit_valid_o), .commit_pc_i(commit_pc_o),
        .commit_instr_i(commit_instr_o), .commit_wen_i(commit_wen_o),
        .commit_rd_i(commit_rd_o), .commit_data_i(commit_data_o), .ebreak_i(ebreak_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci taps 16 14 13 11
    function automatic logic next_lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic bit load_cases();
        int          fd;
        int          got;
        string       line;
        logic [7:0]  kind;
        logic [31:0] word;
        logic [63:0] expv;
        fd = $fopen("dv/pipe_cases.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while (!$feof(fd) && ncases < MAX_CASES) begin
            line = "";
            got  = $fgets(line, fd);
            if (got > 0 && line.len() > 2 && line[0] != "#") begin
                got = $sscanf(line, "%c %h %h", kind, word, expv);
                if (got == 3) begin
                    case_kind[ncases] = kind;
                    case_word[ncases] = word;
                    case_exp[ncases]  = expv;
                    ncases++;
                end
            end
        end
        $fclose(fd);
        return ncases > 0;
    endfunction

    task automatic run_line(input logic [7:0] kind, input logic [31:0] word,
                            input logic [63:0] expv);
        logic b0;
        logic b1;
        b0      = next_lfsr_bit();
        b1      = next_lfsr_bit();
        valid_i = (kind == "I");
        flush_i = 1'b0;
        instr_i = word;
        exp_val = expv[XLEN-1:0];
        if (b0 && b1) begin
            enable_i = 1'b0;
            @(posedge clk);
            #2;
        end
        enable_i = 1'b1;
        flush_i  = (kind == "F");
        @(posedge clk);
        #2;
        if (kind == "I") begin
            pc_i = pc_i + 64'd4;
        end
    endtask

    always @(posedge clk) begin
        if (armed && !done) begin
            cycles++;
            if (cycles > cycle_limit) begin
                $display("timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("sim failed");
                $finish;
            end
        end
    end

    initial begin
        int fails;
        rst_i    = 1'b1;
        enable_i = 1'b0;
        flush_i  = 1'b0;
        valid_i  = 1'b0;
        pc_i     = '0;
        instr_i  = '0;
        exp_val  = '0;
        armed    = 1'b0;
        done     = 1'b0;
        cycles   = 0;
        ncases   = 0;
        lfsr     = 16'd13;
        if (!load_cases()) begin
            $display("could not read any case lines from dv/pipe_cases.txt");
            $display("sim failed");
            $finish;
        end else begin
            cycle_limit = 4 * ncases + 40;
            armed       = 1'b1;
            repeat (5) @(posedge clk);
            #2;
            rst_i    = 1'b0;
            enable_i = 1'b1;
            for (int i = 0; i < ncases; i++) begin
                run_line(case_kind[i], case_word[i], case_exp[i]);
            end
            valid_i  = 1'b0;
            flush_i  = 1'b0;
            enable_i = 1'b1;
            while (pending != 0) begin
                @(posedge clk);
                #2;
            end
            // idle cycles to catch stray commits
            repeat (4) @(posedge clk);
            #2;
            done  = 1'b1;
            fails = mismatch_cnt + stray_cnt + dut_i.props_i.fail_cnt;
            $write("errors: %0d mismatches, %0d unexpected commits, ",
                   mismatch_cnt, stray_cnt);
            $display("%0d assertion failures, %0d commits checked",
                     dut_i.props_i.fail_cnt, checked_cnt);
            if (fails == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dv/pipe_checker.sv ====
// commit checker
`default_nettype none
`timescale 1ns/1ps

module pipe_checker #(
    parameter int XLEN = pipe_pkg::xlen
) (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire                          enable_i,
    input  wire                          flush_i,
    input  wire                          valid_i,
    input  wire  [pipe_pkg::xlen-1:0]    pc_i,
    input  wire  [pipe_pkg::ilen-1:0]    instr_i,
    input  wire  [XLEN-1:0]              exp_i,
    input  wire                          commit_valid_i,
    input  wire  [pipe_pkg::xlen-1:0]    commit_pc_i,
    input  wire  [pipe_pkg::ilen-1:0]    commit_instr_i,
    input  wire                          commit_wen_i,
    input  wire  [4:0]                   commit_rd_i,
    input  wire  [XLEN-1:0]              commit_data_i,
    input  wire                          ebreak_i,
    output int                           mismatch_cnt_o,
    output int                           stray_cnt_o,
    output int                           checked_cnt_o,
    output int                           pending_o
);

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    logic [63:0]     q_pc [$];
    logic [31:0]     q_instr [$];
    logic [XLEN-1:0] q_exp [$];
    int              mismatches = 0;
    int              strays = 0;
    int              checked = 0;
    int              pending = 0;

    assign mismatch_cnt_o = mismatches;
    assign stray_cnt_o    = strays;
    assign checked_cnt_o  = checked;
    assign pending_o      = pending;

    // rv64i forms that write rd
    function automatic logic writes_reg(input logic [31:0] word);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = word[14:12];
        f7 = word[31:25];
        case (word[6:0])
            7'h13: return f3 == 3'b000 || (f3 == 3'b001 && word[31:26] == 6'b0);
            7'h33: return (f7 == 7'h00 && f3 inside {3'b000, 3'b100, 3'b110, 3'b111}) ||
                          (f7 == 7'h20 && f3 == 3'b000);
            7'h37: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_field(input string what, input logic [63:0] got,
                               input logic [63:0] exp, input logic [63:0] pc);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: pc %h %s got %h expected %h",
                     $time, pc, what, got, exp);
            mismatches++;
        end
    endtask

    always @(posedge clk) begin
        logic [63:0]     pc;
        logic [31:0]     word;
        logic [XLEN-1:0] expv;
        if (!rst_i) begin
            // the WB entry retires before a flush empties the rest
            if (enable_i && commit_valid_i) begin
                if (q_pc.size() == 0) begin
                    $display("unexpected commit at %0t: pc %h with nothing outstanding",
                             $time, commit_pc_i);
                    strays++;
                end else begin
                    pc   = q_pc.pop_front();
                    word = q_instr.pop_front();
                    expv = q_exp.pop_front();
                    check_field("pc", commit_pc_i, pc, pc);
                    check_field("instr", 64'(commit_instr_i), 64'(word), pc);
                    check_field("rd", 64'(commit_rd_i), 64'(word[11:7]), pc);
                    check_field("wen", 64'(commit_wen_i), 64'(writes_reg(word)), pc);
                    check_field("ebreak", 64'(ebreak_i), 64'(word == EBREAK_WORD), pc);
                    if (writes_reg(word)) begin
                        check_field("data", 64'(commit_data_i), 64'(expv), pc);
                    end
                    checked++;
                end
            end
            if (flush_i) begin
                q_pc.delete();
                q_instr.delete();
                q_exp.delete();
            end else if (valid_i && enable_i) begin
                q_pc.push_back(pc_i);
                q_instr.push_back(instr_i);
                q_exp.push_back(exp_i);
            end
        end
        pending = q_pc.size();
    end

endmodule

`default_nettype wire

// ==== dv/pipe_props.sv ====
// pipeline commit properties
`default_nettype none
`timescale 1ns/1ps

module pipe_props #(
    parameter int XLEN = pipe_pkg::xlen
) (
    input wire                          clk,
    input wire                          rst_i,
    input wire                          flush_i,
    input wire                          enable_i,
    input wire                          commit_valid_i,
    input wire  [pipe_pkg::xlen-1:0]    commit_pc_i,
    input wire  [pipe_pkg::ilen-1:0]    commit_instr_i,
    input wire                          commit_wen_i,
    input wire  [4:0]                   commit_rd_i,
    input wire  [XLEN-1:0]              commit_data_i,
    input wire                          ebreak_i
);

    int fail_cnt = 0;

    // nothing commits right after a reset or flush
    clear_a: assert property (@(posedge clk) (rst_i || flush_i) |=> !commit_valid_i)
        else begin
            $error("commit valid the cycle after reset or flush");
            fail_cnt++;
        end

    // stalled edge keeps the commit port
    hold_a: assert property (@(posedge clk)
        (!enable_i && !rst_i && !flush_i) |=>
            $stable(commit_valid_i) && $stable(commit_pc_i) && $stable(commit_instr_i) &&
            $stable(commit_wen_i) && $stable(commit_rd_i) && $stable(commit_data_i) &&
            $stable(ebreak_i))
        else begin
            $error("commit outputs changed while enable was low");
            fail_cnt++;
        end

    ebreak_a: assert property (@(posedge clk) ebreak_i |-> commit_valid_i && !commit_wen_i)
        else begin
            $error("ebreak without a valid non-writing commit");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// ==== verilog/pipe_top.sv ====
// three-stage pipeline top
`default_nettype none
`timescale 1ns/1ps

module pipe_top #(
    parameter int XLEN = pipe_pkg::xlen
) (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire                          enable_i,
    input  wire                          flush_i,
    input  wire                          valid_i,
    input  wire  [pipe_pkg::xlen-1:0]    pc_i,
    input  wire  [pipe_pkg::ilen-1:0]    instr_i,
    output logic                         commit_valid_o,
    output logic [pipe_pkg::xlen-1:0]    commit_pc_o,
    output logic [pipe_pkg::ilen-1:0]    commit_instr_o,
    output logic                         commit_wen_o,
    output logic [4:0]                   commit_rd_o,
    output logic [XLEN-1:0]              commit_data_o,
    output logic                         ebreak_o
);

    logic                         stage_flush;
    logic                         id_valid;
    logic [pipe_pkg::xlen-1:0]    id_pc;
    logic [pipe_pkg::ilen-1:0]    id_instr;
    logic [4:0]                   dec_rs1;
    logic [4:0]                   dec_rs2;
    logic [4:0]                   dec_rd;
    logic [pipe_pkg::xlen-1:0]    dec_imm_full;
    logic [XLEN-1:0]              dec_imm;
    pipe_pkg::alu_op_e            dec_alu_op;
    logic                         dec_srcb_imm;
    logic                         dec_wen;
    logic                         dec_ebreak;
    logic [XLEN-1:0]              rf_busa;
    logic [XLEN-1:0]              rf_busb;
    logic                         ex_valid;
    logic [pipe_pkg::xlen-1:0]    ex_pc;
    logic [pipe_pkg::ilen-1:0]    ex_instr;
    logic [4:0]                   ex_rd;
    logic [4:0]                   ex_rs1;
    logic [4:0]                   ex_rs2;
    logic [XLEN-1:0]              ex_busa;
    logic [XLEN-1:0]              ex_busb;
    logic [XLEN-1:0]              ex_imm;
    pipe_pkg::alu_op_e            ex_alu_op;
    logic                         ex_srcb_imm;
    logic                         ex_wen;
    logic                         ex_ebreak;
    logic [XLEN-1:0]              alu_result;
    logic                         wb_valid;
    logic                         wb_wen;
    logic                         wb_ebreak;
    logic                         wb_write;

    assign stage_flush = rst_i | flush_i;
    // sign-extended immediate narrowed to the data width
    assign dec_imm     = dec_imm_full[XLEN-1:0];
    assign wb_write    = wb_valid & wb_wen;

    id_reg id_reg_i (
        .clk(clk), .flush_i(stage_flush), .enable_i(enable_i), .valid_i(valid_i),
        .pc_i(pc_i), .instr_i(instr_i),
        .valid_o(id_valid), .pc_o(id_pc), .instr_o(id_instr)
    );

    instr_decoder instr_decoder_i (
        .instr_i(id_instr), .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd),
        .imm_o(dec_imm_full), .alu_op_o(dec_alu_op), .srcb_imm_o(dec_srcb_imm),
        .wen_o(dec_wen), .ebreak_o(dec_ebreak)
    );

    reg_file #(.XLEN(XLEN)) reg_file_i (
        .clk(clk), .rst_i(rst_i), .raddr_a_i(dec_rs1), .raddr_b_i(dec_rs2),
        .we_i(wb_write), .waddr_i(commit_rd_o), .wdata_i(commit_data_o),
        .rdata_a_o(rf_busa), .rdata_b_o(rf_busb)
    );

    ex_reg #(.XLEN(XLEN)) ex_reg_i (
        .clk(clk), .flush_i(stage_flush), .enable_i(enable_i), .valid_i(id_valid),
        .pc_i(id_pc), .instr_i(id_instr), .rd_i(dec_rd), .rs1_i(dec_rs1), .rs2_i(dec_rs2),
        .busa_i(rf_busa), .busb_i(rf_busb), .imm_i(dec_imm), .alu_op_i(dec_alu_op),
        .srcb_imm_i(dec_srcb_imm), .wen_i(dec_wen), .ebreak_i(dec_ebreak),
        .valid_o(ex_valid), .pc_o(ex_pc), .instr_o(ex_instr), .rd_o(ex_rd),
        .rs1_o(ex_rs1), .rs2_o(ex_rs2), .busa_o(ex_busa), .busb_o(ex_busb),
        .imm_o(ex_imm), .alu_op_o(ex_alu_op), .srcb_imm_o(ex_srcb_imm),
        .wen_o(ex_wen), .ebreak_o(ex_ebreak)
    );

    alu_stage #(.XLEN(XLEN)) alu_stage_i (
        .rs1_i(ex_rs1), .rs2_i(ex_rs2), .busa_i(ex_busa), .busb_i(ex_busb),
        .imm_i(ex_imm), .alu_op_i(ex_alu_op), .srcb_imm_i(ex_srcb_imm),
        .fwd_valid_i(wb_write), .fwd_rd_i(commit_rd_o), .fwd_data_i(commit_data_o),
        .result_o(alu_result)
    );

    wb_reg #(.XLEN(XLEN)) wb_reg_i (
        .clk(clk), .flush_i(stage_flush), .enable_i(enable_i), .valid_i(ex_valid),
        .pc_i(ex_pc), .instr_i(ex_instr), .rd_i(ex_rd), .wen_i(ex_wen),
        .data_i(alu_result), .ebreak_i(ex_ebreak),
        .valid_o(wb_valid), .pc_o(commit_pc_o), .instr_o(commit_instr_o),
        .rd_o(commit_rd_o), .wen_o(wb_wen), .data_o(commit_data_o), .ebreak_o(wb_ebreak)
    );

    // bubbles may carry a stale wen, qualify with valid
    assign commit_valid_o = wb_valid;
    assign commit_wen_o   = wb_write;
    assign ebreak_o       = wb_valid & wb_ebreak;

endmodule

`default_nettype wire

// ==== verilog/wb_reg.sv ====
// EX/WB stage register
`default_nettype none
`timescale 1ns/1ps

module wb_reg #(
    parameter int XLEN = pipe_pkg::xlen
) (
    input  wire                          clk,
    input  wire                          flush_i,
    input  wire                          enable_i,
    input  wire                          valid_i,
    input  wire  [pipe_pkg::xlen-1:0]    pc_i,
    input  wire  [pipe_pkg::ilen-1:0]    instr_i,
    input  wire  [4:0]                   rd_i,
    input  wire                          wen_i,
    input  wire  [XLEN-1:0]              data_i,
    input  wire                          ebreak_i,
    output logic                         valid_o,
    output logic [pipe_pkg::xlen-1:0]    pc_o,
    output logic [pipe_pkg::ilen-1:0]    instr_o,
    output logic [4:0]                   rd_o,
    output logic                         wen_o,
    output logic [XLEN-1:0]              data_o,
    output logic                         ebreak_o
);

    always_ff @(posedge clk) begin
        if (flush_i) begin
            valid_o  <= 1'b0;
            pc_o     <= '0;
            instr_o  <= '0;
            rd_o     <= '0;
            wen_o    <= 1'b0;
            data_o   <= '0;
            ebreak_o <= 1'b0;
        end else if (enable_i) begin
            valid_o  <= valid_i;
            pc_o     <= pc_i;
            instr_o  <= instr_i;
            rd_o     <= rd_i;
            wen_o    <= wen_i;
            data_o   <= data_i;
            ebreak_o <= ebreak_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu_stage.sv ====
// execute stage with forwarding
`default_nettype none
`timescale 1ns/1ps

module alu_stage #(
    parameter int XLEN = pipe_pkg::xlen
) (
    input  wire  [4:0]          rs1_i,
    input  wire  [4:0]          rs2_i,
    input  wire  [XLEN-1:0]     busa_i,
    input  wire  [XLEN-1:0]     busb_i,
    input  wire  [XLEN-1:0]     imm_i,
    input  pipe_pkg::alu_op_e   alu_op_i,
    input  wire                 srcb_imm_i,
    input  wire                 fwd_valid_i,
    input  wire  [4:0]          fwd_rd_i,
    input  wire  [XLEN-1:0]     fwd_data_i,
    output logic [XLEN-1:0]     result_o
);

    localparam int SHW = $clog2(XLEN);

    logic            fwd_a;
    logic            fwd_b;
    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] regb;
    logic [XLEN-1:0] opb;

    // EX/WB result overrides a stale register read
    assign fwd_a = fwd_valid_i && fwd_rd_i != 5'd0 && fwd_rd_i == rs1_i;
    assign fwd_b = fwd_valid_i && fwd_rd_i != 5'd0 && fwd_rd_i == rs2_i;

    assign opa  = fwd_a ? fwd_data_i : busa_i;
    assign regb = fwd_b ? fwd_data_i : busb_i;
    assign opb  = srcb_imm_i ? imm_i : regb;

    always_comb begin
        case (alu_op_i)
            pipe_pkg::ALU_ADD:   result_o = opa + opb;
            pipe_pkg::ALU_SUB:   result_o = opa - opb;
            pipe_pkg::ALU_AND:   result_o = opa & opb;
            pipe_pkg::ALU_OR:    result_o = opa | opb;
            pipe_pkg::ALU_XOR:   result_o = opa ^ opb;
            pipe_pkg::ALU_SLL:   result_o = opa << opb[SHW-1:0];
            // lui passes the shifted immediate
            pipe_pkg::ALU_PASSB: result_o = opb;
            default:             result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/ex_reg.sv ====
// ID/EX stage register
`default_nettype none
`timescale 1ns/1ps

module ex_reg #(
    parameter int XLEN = pipe_pkg::xlen
) (
    input  wire                          clk,
    input  wire                          flush_i,
    input  wire                          enable_i,
    input  wire                          valid_i,
    input  wire  [pipe_pkg::xlen-1:0]    pc_i,
    input  wire  [pipe_pkg::ilen-1:0]    instr_i,
    input  wire  [4:0]                   rd_i,
    input  wire  [4:0]                   rs1_i,
    input  wire  [4:0]                   rs2_i,
    input  wire  [XLEN-1:0]              busa_i,
    input  wire  [XLEN-1:0]              busb_i,
    input  wire  [XLEN-1:0]              imm_i,
    input  pipe_pkg::alu_op_e            alu_op_i,
    input  wire                          srcb_imm_i,
    input  wire                          wen_i,
    input  wire                          ebreak_i,
    output logic                         valid_o,
    output logic [pipe_pkg::xlen-1:0]    pc_o,
    output logic [pipe_pkg::ilen-1:0]    instr_o,
    output logic [4:0]                   rd_o,
    output logic [4:0]                   rs1_o,
    output logic [4:0]                   rs2_o,
    output logic [XLEN-1:0]              busa_o,
    output logic [XLEN-1:0]              busb_o,
    output logic [XLEN-1:0]              imm_o,
    output pipe_pkg::alu_op_e            alu_op_o,
    output logic                         srcb_imm_o,
    output logic                         wen_o,
    output logic                         ebreak_o
);

    always_ff @(posedge clk) begin
        if (flush_i) begin
            valid_o    <= 1'b0;
            pc_o       <= '0;
            instr_o    <= '0;
            rd_o       <= '0;
            rs1_o      <= '0;
            rs2_o      <= '0;
            busa_o     <= '0;
            busb_o     <= '0;
            imm_o      <= '0;
            alu_op_o   <= pipe_pkg::ALU_ADD;
            srcb_imm_o <= 1'b0;
            wen_o      <= 1'b0;
            ebreak_o   <= 1'b0;
        end else if (enable_i) begin
            valid_o    <= valid_i;
            pc_o       <= pc_i;
            instr_o    <= instr_i;
            rd_o       <= rd_i;
            rs1_o      <= rs1_i;
            rs2_o      <= rs2_i;
            busa_o     <= busa_i;
            busb_o     <= busb_i;
            imm_o      <= imm_i;
            alu_op_o   <= alu_op_i;
            srcb_imm_o <= srcb_imm_i;
            wen_o      <= wen_i;
            ebreak_o   <= ebreak_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
// integer register file
`default_nettype none
`timescale 1ns/1ps

module reg_file #(
    parameter int XLEN = pipe_pkg::xlen
) (
    input  wire             clk,
    input  wire             rst_i,
    input  wire  [4:0]      raddr_a_i,
    input  wire  [4:0]      raddr_b_i,
    input  wire             we_i,
    input  wire  [4:0]      waddr_i,
    input  wire  [XLEN-1:0] wdata_i,
    output logic [XLEN-1:0] rdata_a_o,
    output logic [XLEN-1:0] rdata_b_o
);

    logic [XLEN-1:0] regs [pipe_pkg::nreg];

    // x0 reads zero, same-cycle write is bypassed
    function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < pipe_pkg::nreg; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = read_port(raddr_a_i);
    assign rdata_b_o = read_port(raddr_b_i);

endmodule

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
// instruction decoder
`default_nettype none
`timescale 1ns/1ps

module instr_decoder (
    input  wire  [pipe_pkg::ilen-1:0]    instr_i,
    output logic [4:0]                   rs1_o,
    output logic [4:0]                   rs2_o,
    output logic [4:0]                   rd_o,
    output logic [pipe_pkg::xlen-1:0]    imm_o,
    output pipe_pkg::alu_op_e            alu_op_o,
    output logic                         srcb_imm_o,
    output logic                         wen_o,
    output logic                         ebreak_o
);

    localparam logic [pipe_pkg::ilen-1:0] EBREAK_WORD = 32'h0010_0073;

    pipe_pkg::opcode_e opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;

    assign opcode = pipe_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // register fields are taken as is, even when the format has none
    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    always_comb begin
        imm_o      = {{(pipe_pkg::xlen-12){instr_i[31]}}, instr_i[31:20]};
        alu_op_o   = pipe_pkg::ALU_ADD;
        srcb_imm_o = 1'b0;
        wen_o      = 1'b0;
        ebreak_o   = 1'b0;
        case (opcode)
            pipe_pkg::OP_IMM: begin
                srcb_imm_o = 1'b1;
                if (funct3 == 3'b000) begin
                    wen_o = 1'b1;
                end else if (funct3 == 3'b001 && instr_i[31:26] == 6'b0) begin
                    // rv64 slli takes a 6-bit shamt
                    alu_op_o = pipe_pkg::ALU_SLL;
                    wen_o    = 1'b1;
                end
            end
            pipe_pkg::OP_REG: begin
                if (funct7 == 7'b0000000) begin
                    wen_o = 1'b1;
                    case (funct3)
                        3'b000:  alu_op_o = pipe_pkg::ALU_ADD;
                        3'b100:  alu_op_o = pipe_pkg::ALU_XOR;
                        3'b110:  alu_op_o = pipe_pkg::ALU_OR;
                        3'b111:  alu_op_o = pipe_pkg::ALU_AND;
                        default: wen_o    = 1'b0;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    alu_op_o = pipe_pkg::ALU_SUB;
                    wen_o    = 1'b1;
                end
            end
            pipe_pkg::OP_LUI: begin
                imm_o      = {{(pipe_pkg::xlen-32){instr_i[31]}}, instr_i[31:12], 12'b0};
                alu_op_o   = pipe_pkg::ALU_PASSB;
                srcb_imm_o = 1'b1;
                wen_o      = 1'b1;
            end
            pipe_pkg::OP_SYSTEM: begin
                ebreak_o = (instr_i == EBREAK_WORD);
            end
            default: begin
                // unknown word retires without a write
                wen_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/id_reg.sv ====
// IF/ID stage register
`default_nettype none
`timescale 1ns/1ps

module id_reg (
    input  wire                          clk,
    input  wire                          flush_i,
    input  wire                          enable_i,
    input  wire                          valid_i,
    input  wire  [pipe_pkg::xlen-1:0]    pc_i,
    input  wire  [pipe_pkg::ilen-1:0]    instr_i,
    output logic                         valid_o,
    output logic [pipe_pkg::xlen-1:0]    pc_o,
    output logic [pipe_pkg::ilen-1:0]    instr_o
);

    // valid loads with the data so a stall holds the slot
    always_ff @(posedge clk) begin
        if (flush_i) begin
            valid_o <= 1'b0;
            pc_o    <= '0;
            instr_o <= '0;
        end else if (enable_i) begin
            valid_o <= valid_i;
            pc_o    <= pc_i;
            instr_o <= instr_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pipe_pkg.sv ====
// pipeline shared definitions
`default_nettype none

package pipe_pkg;

    // data width, default of the top level XLEN
    localparam int xlen = 64;

    // instruction width
    localparam int ilen = 32;

    // architectural register count
    localparam int nreg = 32;

    // major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // alu operations
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_SLL   = 3'd5,
        ALU_PASSB = 3'd6
    } alu_op_e;

endpackage

`default_nettype wire
